//--- sources.f
rtl/race_pkg.sv
rtl/video_timing.sv
rtl/car_physics.sv
rtl/race_control.sv
rtl/pixel_compositor.sv
rtl/race_top.sv
dv/race_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= race_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Test OK

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/race_tb.sv
`timescale 1ns/1ps

module race_tb;

    import race_pkg::*;

    localparam int H_ACTIVE     = 32;
    localparam int H_TOTAL      = 40;
    localparam int V_ACTIVE     = 20;
    localparam int V_TOTAL      = 24;
    localparam int H_SYNC_W     = 4;
    localparam int V_SYNC_W     = 2;
    localparam int LAPS_TO_WIN  = 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    localparam car_state_t CAR1_START = '{pos: 8'd0, lane: 4'd4, speed: 4'd0};
    localparam car_state_t CAR2_START = '{pos: 8'd0, lane: 4'd11, speed: 4'd0};

    typedef struct packed {
        logic         next_level;
        car_ctrl_t    ctrl1;
        car_ctrl_t    ctrl2;
        logic [7:0]   reps;
        game_state_e  exp_state;
        game_result_e exp_result;
        speed_t       exp_speed1;
        speed_t       exp_speed2;
        logic         exp_vib1;
    } frame_row_t;

    logic         i_clk;
    logic         i_rst_n;
    logic         i_next_state;
    car_ctrl_t    i_car1_ctrl;
    car_ctrl_t    i_car2_ctrl;
    logic         o_h_sync;
    logic         o_v_sync;
    rgb_t         o_rgb;
    logic         o_rgb_valid;
    logic         o_car1_vibrate;
    logic         o_car2_vibrate;
    speed_t       o_car1_speed;
    speed_t       o_car2_speed;
    game_state_e  o_game_state;
    game_result_e o_result;

    frame_row_t   rows[$];
    int           errors = 0;
    int           checks = 0;
    int           cycle_cnt = 0;
    int           cycle_limit = 0;

    // reference model state, advanced on every rising clock edge.
    int           m_h;
    int           m_v;
    logic         m_tick;
    logic         m_next_q;
    logic         m_wrap1;
    logic         m_wrap2;
    logic         m_vib1;
    logic         m_vib2;
    logic         m_live;
    logic         tick_now;
    int           m_lap1;
    int           m_lap2;
    game_state_e  m_state;
    game_result_e m_result;
    car_state_t   m_car1;
    car_state_t   m_car2;
    rgb_t         exp_rgb;
    logic         exp_valid;
    logic         exp_hs;
    logic         exp_vs;
    event         tick_seen;

    race_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .H_SYNC_W    (H_SYNC_W),
        .V_SYNC_W    (V_SYNC_W),
        .LAPS_TO_WIN (LAPS_TO_WIN)
    ) u_race_top (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_next_state   (i_next_state),
        .i_car1_ctrl    (i_car1_ctrl),
        .i_car2_ctrl    (i_car2_ctrl),
        .o_h_sync       (o_h_sync),
        .o_v_sync       (o_v_sync),
        .o_rgb          (o_rgb),
        .o_rgb_valid    (o_rgb_valid),
        .o_car1_vibrate (o_car1_vibrate),
        .o_car2_vibrate (o_car2_vibrate),
        .o_car1_speed   (o_car1_speed),
        .o_car2_speed   (o_car2_speed),
        .o_game_state   (o_game_state),
        .o_result       (o_result)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic log_mismatch(input string name, input string got, input string exp);
        errors++;
        $display("ERROR t=%0t %s: got %s, expected %s", $time, name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            log_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
        end
    endtask

    task automatic check_speed(input string name, input speed_t got, input speed_t exp);
        checks++;
        if (got !== exp) begin
            log_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        checks++;
        if (got !== exp) begin
            log_mismatch(name, $sformatf("%06h", got), $sformatf("%06h", exp));
        end
    endtask

    task automatic check_state(input string name, input game_state_e got,
                               input game_state_e exp);
        checks++;
        if (got !== exp) begin
            log_mismatch(name, got.name(), exp.name());
        end
    endtask

    task automatic check_result(input string name, input game_result_e got,
                                input game_result_e exp);
        checks++;
        if (got !== exp) begin
            log_mismatch(name, got.name(), exp.name());
        end
    endtask

    task automatic add_row(input int next, input int acc1, input steer_e steer1, input int acc2,
                           input steer_e steer2, input int reps, input game_state_e st,
                           input game_result_e res, input int s1, input int s2, input int vib1);
        frame_row_t row;
        row.next_level  = 1'(next);
        row.ctrl1.acc   = 3'(acc1);
        row.ctrl1.steer = steer1;
        row.ctrl2.acc   = 3'(acc2);
        row.ctrl2.steer = steer2;
        row.reps        = 8'(reps);
        row.exp_state   = st;
        row.exp_result  = res;
        row.exp_speed1  = speed_t'(s1);
        row.exp_speed2  = speed_t'(s2);
        row.exp_vib1    = 1'(vib1);
        rows.push_back(row);
    endtask

    // a car is a square sprite whose four corner pixels are transparent.
    function automatic logic car_covers(input int h, input int v, input car_state_t car);
        int   dx;
        int   dy;
        logic corner;
        dx = h - (int'(car.pos) % H_ACTIVE);
        dy = v - int'(car.lane);
        if (dx < 0 || dx >= CAR_SIZE || dy < 0 || dy >= CAR_SIZE) begin
            return 1'b0;
        end
        corner = (dx == 0 || dx == CAR_SIZE - 1) && (dy == 0 || dy == CAR_SIZE - 1);
        return !corner;
    endfunction

    function automatic rgb_t pixel_colour(input int h, input int v, input car_state_t c1,
                                          input car_state_t c2);
        if (car_covers(h, v, c1)) begin
            return COLOR_CAR1;
        end
        if (car_covers(h, v, c2)) begin
            return COLOR_CAR2;
        end
        if (h == 0) begin
            return COLOR_FINISH;
        end
        return ((v / 4) % 2 == 1) ? COLOR_TRACK_B : COLOR_TRACK_A;
    endfunction

    task automatic move_car(inout car_state_t car, input car_ctrl_t ctrl, input logic racing,
                            output logic wrap, output logic vib);
        int   speed;
        int   lane;
        int   pos;
        logic blocked;
        blocked = 1'b0;
        speed   = int'(car.speed) + int'(ctrl.acc) - 4;
        lane    = int'(car.lane);
        if (speed > int'(MAX_SPEED)) begin
            speed = int'(MAX_SPEED);
        end else if (speed < 0) begin
            speed = 0;
        end
        if (ctrl.steer == STEER_LEFT) begin
            if (lane == 0) begin
                blocked = 1'b1;
            end else begin
                lane = lane - 1;
            end
        end else if (ctrl.steer == STEER_RIGHT) begin
            if (lane == int'(LANE_MAX)) begin
                blocked = 1'b1;
            end else begin
                lane = lane + 1;
            end
        end
        pos  = int'(car.pos) + speed;
        wrap = racing && (pos > 255);
        vib  = racing && blocked;
        if (racing) begin
            car.speed = speed_t'(speed);
            car.lane  = lane_t'(lane);
            car.pos   = pos_t'(pos % 256);
        end
    endtask

    task automatic reset_model();
        m_h       = 0;
        m_v       = 0;
        m_tick    = 1'b0;
        m_next_q  = 1'b0;
        m_wrap1   = 1'b0;
        m_wrap2   = 1'b0;
        m_vib1    = 1'b0;
        m_vib2    = 1'b0;
        m_live    = 1'b0;
        m_lap1    = 0;
        m_lap2    = 0;
        m_state   = GAME_IDLE;
        m_result  = RESULT_NONE;
        m_car1    = CAR1_START;
        m_car2    = CAR2_START;
        exp_rgb   = COLOR_BLANK;
        exp_valid = 1'b0;
        exp_hs    = 1'b1;
        exp_vs    = 1'b1;
    endtask

    task automatic step_model();
        logic rise;
        logic racing;
        logic clear;
        logic win1;
        logic win2;
        // the video outputs show the pixel and car states from before this edge.
        exp_valid = (m_h < H_ACTIVE) && (m_v < V_ACTIVE);
        exp_rgb   = exp_valid ? pixel_colour(m_h, m_v, m_car1, m_car2) : COLOR_BLANK;
        exp_hs    = !(m_h >= H_ACTIVE && m_h < H_ACTIVE + H_SYNC_W);
        exp_vs    = !(m_v >= V_ACTIVE && m_v < V_ACTIVE + V_SYNC_W);
        rise      = i_next_state && !m_next_q;
        racing    = (m_state == GAME_RACING);
        clear     = (m_state == GAME_FINISHED) && rise;
        win1      = m_wrap1 && (m_lap1 + 1 == LAPS_TO_WIN);
        win2      = m_wrap2 && (m_lap2 + 1 == LAPS_TO_WIN);
        case (m_state)
            GAME_IDLE: begin
                if (rise) begin
                    m_state = GAME_RACING;
                end
            end
            GAME_RACING: begin
                m_lap1 = m_lap1 + int'(m_wrap1);
                m_lap2 = m_lap2 + int'(m_wrap2);
                if (win1 || win2) begin
                    m_state = GAME_FINISHED;
                    if (win1 && win2) begin
                        m_result = RESULT_TIE;
                    end else if (win1) begin
                        m_result = RESULT_CAR1;
                    end else begin
                        m_result = RESULT_CAR2;
                    end
                end
            end
            default: begin
                if (rise) begin
                    m_state  = GAME_IDLE;
                    m_result = RESULT_NONE;
                    m_lap1   = 0;
                    m_lap2   = 0;
                end
            end
        endcase
        if (clear) begin
            m_car1  = CAR1_START;
            m_car2  = CAR2_START;
            m_wrap1 = 1'b0;
            m_wrap2 = 1'b0;
            m_vib1  = 1'b0;
            m_vib2  = 1'b0;
        end else begin
            m_wrap1 = 1'b0;
            m_wrap2 = 1'b0;
            if (m_tick) begin
                move_car(m_car1, i_car1_ctrl, racing, m_wrap1, m_vib1);
                move_car(m_car2, i_car2_ctrl, racing, m_wrap2, m_vib2);
            end
        end
        m_tick   = (m_h == H_TOTAL - 1) && (m_v == V_TOTAL - 1);
        m_next_q = i_next_state;
        if (m_h == H_TOTAL - 1) begin
            m_h = 0;
            m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
        end else begin
            m_h = m_h + 1;
        end
    endtask

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reset_model();
        end else begin
            tick_now = m_tick;
            step_model();
            m_live = 1'b1;
            if (tick_now) begin
                -> tick_seen;
            end
        end
    end

    // every output is compared with the model in the middle of each cycle.
    always @(negedge i_clk) begin
        if (m_live) begin
            check_bit("o_rgb_valid", o_rgb_valid, exp_valid);
            check_rgb("o_rgb", o_rgb, exp_rgb);
            check_bit("o_h_sync", o_h_sync, exp_hs);
            check_bit("o_v_sync", o_v_sync, exp_vs);
            check_bit("o_car1_vibrate", o_car1_vibrate, m_vib1);
            check_bit("o_car2_vibrate", o_car2_vibrate, m_vib2);
            check_speed("o_car1_speed", o_car1_speed, m_car1.speed);
            check_speed("o_car2_speed", o_car2_speed, m_car2.speed);
            check_state("o_game_state", o_game_state, m_state);
            check_result("o_result", o_result, m_result);
        end
    end

    task automatic apply_row(input frame_row_t row);
        i_next_state = row.next_level;
        i_car1_ctrl  = row.ctrl1;
        i_car2_ctrl  = row.ctrl2;
    endtask

    task automatic check_row(input frame_row_t row);
        check_state("o_game_state", o_game_state, row.exp_state);
        check_result("o_result", o_result, row.exp_result);
        check_speed("o_car1_speed", o_car1_speed, row.exp_speed1);
        check_speed("o_car2_speed", o_car2_speed, row.exp_speed2);
        check_bit("o_car1_vibrate", o_car1_vibrate, row.exp_vib1);
    endtask

    initial begin
        @(posedge i_clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int total_frames;
        i_rst_n      = 1'b0;
        i_next_state = 1'b0;
        i_car1_ctrl  = '0;
        i_car2_ctrl  = '0;
        total_frames = 0;
        // each row is held for reps frames; the expected values hold right after each tick.
        add_row(0, 7, STEER_NONE, 7, STEER_NONE, 1, GAME_IDLE, RESULT_NONE, 0, 0, 0);
        add_row(1, 7, STEER_NONE, 5, STEER_NONE, 1, GAME_RACING, RESULT_NONE, 3, 1, 0);
        add_row(1, 7, STEER_LEFT, 6, STEER_NONE, 1, GAME_RACING, RESULT_NONE, 6, 3, 0);
        add_row(1, 7, STEER_LEFT, 0, STEER_NONE, 1, GAME_RACING, RESULT_NONE, 9, 0, 0);
        add_row(1, 7, STEER_LEFT, 3, STEER_NONE, 1, GAME_RACING, RESULT_NONE, 12, 0, 0);
        add_row(1, 7, STEER_LEFT, 7, STEER_RIGHT, 1, GAME_RACING, RESULT_NONE, 12, 3, 0);
        add_row(1, 7, STEER_LEFT, 4, STEER_NONE, 1, GAME_RACING, RESULT_NONE, 12, 3, 1);
        add_row(1, 7, STEER_NONE, 4, STEER_NONE, 1, GAME_RACING, RESULT_NONE, 12, 3, 0);
        add_row(1, 7, STEER_NONE, 4, STEER_HOLD, 38, GAME_RACING, RESULT_NONE, 12, 3, 0);
        add_row(0, 7, STEER_NONE, 7, STEER_NONE, 1, GAME_FINISHED, RESULT_CAR1, 12, 3, 0);
        add_row(1, 7, STEER_RIGHT, 7, STEER_NONE, 1, GAME_IDLE, RESULT_NONE, 0, 0, 0);
        add_row(1, 7, STEER_NONE, 7, STEER_NONE, 1, GAME_IDLE, RESULT_NONE, 0, 0, 0);
        foreach (rows[r]) begin
            total_frames += int'(rows[r].reps);
        end
        cycle_limit = (total_frames + 2) * FRAME_CYCLES + 100;

        repeat (3) @(negedge i_clk);
        check_bit("o_rgb_valid", o_rgb_valid, 1'b0);
        check_bit("o_car1_vibrate", o_car1_vibrate, 1'b0);
        check_bit("o_car2_vibrate", o_car2_vibrate, 1'b0);
        check_state("o_game_state", o_game_state, GAME_IDLE);
        check_result("o_result", o_result, RESULT_NONE);
        i_rst_n = 1'b1;

        for (int r = 0; r < rows.size(); r++) begin
            for (int k = 0; k < int'(rows[r].reps); k++) begin
                apply_row(rows[r]);
                @(tick_seen);
                @(negedge i_clk);
                check_row(rows[r]);
            end
        end
        @(negedge i_clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/race_top.sv
`timescale 1ns/1ps

module race_top #(
    parameter int H_ACTIVE    = 192,
    parameter int H_TOTAL     = 240,
    parameter int V_ACTIVE    = 144,
    parameter int V_TOTAL     = 160,
    parameter int H_SYNC_W    = 16,
    parameter int V_SYNC_W    = 4,
    parameter int LAPS_TO_WIN = 3
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_next_state,
    input  race_pkg::car_ctrl_t    i_car1_ctrl,
    input  race_pkg::car_ctrl_t    i_car2_ctrl,
    output logic                   o_h_sync,
    output logic                   o_v_sync,
    output race_pkg::rgb_t         o_rgb,
    output logic                   o_rgb_valid,
    output logic                   o_car1_vibrate,
    output logic                   o_car2_vibrate,
    output race_pkg::speed_t       o_car1_speed,
    output race_pkg::speed_t       o_car2_speed,
    output race_pkg::game_state_e  o_game_state,
    output race_pkg::game_result_e o_result
);

    import race_pkg::*;

    logic [7:0] pix_h;
    logic [7:0] pix_v;
    logic       pix_active;
    logic       frame_tick;
    logic       h_sync_raw;
    logic       v_sync_raw;
    logic       racing;
    logic       clear;
    logic       car1_lap_wrap;
    logic       car2_lap_wrap;
    car_state_t car1_state;
    car_state_t car2_state;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .H_SYNC_W (H_SYNC_W),
        .V_SYNC_W (V_SYNC_W)
    ) u_video_timing (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_h          (pix_h),
        .o_v          (pix_v),
        .o_active     (pix_active),
        .o_frame_tick (frame_tick),
        .o_h_sync     (h_sync_raw),
        .o_v_sync     (v_sync_raw)
    );

    car_physics #(
        .START_LANE (4'd4)
    ) u_car1 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_racing     (racing),
        .i_clear      (clear),
        .i_ctrl       (i_car1_ctrl),
        .o_state      (car1_state),
        .o_lap_wrap   (car1_lap_wrap),
        .o_vibrate    (o_car1_vibrate)
    );

    car_physics #(
        .START_LANE (4'd11)
    ) u_car2 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_racing     (racing),
        .i_clear      (clear),
        .i_ctrl       (i_car2_ctrl),
        .o_state      (car2_state),
        .o_lap_wrap   (car2_lap_wrap),
        .o_vibrate    (o_car2_vibrate)
    );

    race_control #(
        .LAPS_TO_WIN (LAPS_TO_WIN)
    ) u_race_control (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_next_state    (i_next_state),
        .i_car1_lap_wrap (car1_lap_wrap),
        .i_car2_lap_wrap (car2_lap_wrap),
        .o_racing        (racing),
        .o_clear         (clear),
        .o_game_state    (o_game_state),
        .o_result        (o_result),
        .o_car1_lap      (),
        .o_car2_lap      ()
    );

    pixel_compositor #(
        .H_ACTIVE (H_ACTIVE)
    ) u_pixel_compositor (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_h         (pix_h),
        .i_v         (pix_v),
        .i_active    (pix_active),
        .i_h_sync    (h_sync_raw),
        .i_v_sync    (v_sync_raw),
        .i_car1      (car1_state),
        .i_car2      (car2_state),
        .o_rgb       (o_rgb),
        .o_rgb_valid (o_rgb_valid),
        .o_h_sync    (o_h_sync),
        .o_v_sync    (o_v_sync)
    );

    assign o_car1_speed = car1_state.speed;
    assign o_car2_speed = car2_state.speed;

endmodule

//--- rtl/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor #(
    parameter int H_ACTIVE = 192
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic [7:0]           i_h,
    input  logic [7:0]           i_v,
    input  logic                 i_active,
    input  logic                 i_h_sync,
    input  logic                 i_v_sync,
    input  race_pkg::car_state_t i_car1,
    input  race_pkg::car_state_t i_car2,
    output race_pkg::rgb_t       o_rgb,
    output logic                 o_rgb_valid,
    output logic                 o_h_sync,
    output logic                 o_v_sync
);

    import race_pkg::*;

    logic car1_hit;
    logic car2_hit;
    rgb_t colour;

    // a car covers a CAR_SIZE square with its top left corner at (pos mod width, lane).
    function automatic logic sprite_hit(input logic [7:0] h, input logic [7:0] v,
                                        input car_state_t car);
        logic [7:0] col;
        logic [7:0] row;
        logic [7:0] dx;
        logic [7:0] dy;
        logic       in_box;
        col    = 8'(car.pos % H_ACTIVE);
        row    = {4'd0, car.lane};
        dx     = h - col;
        dy     = v - row;
        in_box = (h >= col) && (dx < 8'(CAR_SIZE)) && (v >= row) && (dy < 8'(CAR_SIZE));
        return in_box && CAR_MASK[{dy[1:0], dx[1:0]}];
    endfunction

    assign car1_hit = sprite_hit(i_h, i_v, i_car1);
    assign car2_hit = sprite_hit(i_h, i_v, i_car2);

    // car 1 is drawn on top when the sprites overlap.
    always_comb begin
        if (car1_hit) begin
            colour = COLOR_CAR1;
        end else if (car2_hit) begin
            colour = COLOR_CAR2;
        end else if (i_h == 8'd0) begin
            colour = COLOR_FINISH;
        end else if (i_v[2]) begin
            colour = COLOR_TRACK_B;
        end else begin
            colour = COLOR_TRACK_A;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rgb <= i_active ? colour : COLOR_BLANK;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rgb_valid <= 1'b0;
            o_h_sync    <= 1'b1;
            o_v_sync    <= 1'b1;
        end else begin
            o_rgb_valid <= i_active;
            o_h_sync    <= i_h_sync;
            o_v_sync    <= i_v_sync;
        end
    end

endmodule

//--- rtl/race_control.sv
`timescale 1ns/1ps

module race_control #(
    parameter int LAPS_TO_WIN = 3
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_next_state,
    input  logic                            i_car1_lap_wrap,
    input  logic                            i_car2_lap_wrap,
    output logic                            o_racing,
    output logic                            o_clear,
    output race_pkg::game_state_e           o_game_state,
    output race_pkg::game_result_e          o_result,
    output logic [race_pkg::LAP_WIDTH-1:0]  o_car1_lap,
    output logic [race_pkg::LAP_WIDTH-1:0]  o_car2_lap
);

    import race_pkg::*;

    localparam logic [LAP_WIDTH-1:0] LAP_LAST = LAP_WIDTH'(LAPS_TO_WIN - 1);

    game_state_e          state_q;
    game_result_e         result_q;
    logic [LAP_WIDTH-1:0] lap1_q;
    logic [LAP_WIDTH-1:0] lap2_q;
    logic                 next_q;
    logic                 next_rise;
    logic                 win1;
    logic                 win2;

    assign next_rise = i_next_state && !next_q;
    assign win1      = i_car1_lap_wrap && (lap1_q == LAP_LAST);
    assign win2      = i_car2_lap_wrap && (lap2_q == LAP_LAST);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            next_q   <= 1'b0;
            state_q  <= GAME_IDLE;
            result_q <= RESULT_NONE;
            lap1_q   <= '0;
            lap2_q   <= '0;
        end else begin
            next_q <= i_next_state;
            case (state_q)
                GAME_IDLE: begin
                    if (next_rise) begin
                        state_q <= GAME_RACING;
                    end
                end
                GAME_RACING: begin
                    if (i_car1_lap_wrap) begin
                        lap1_q <= lap1_q + 1'b1;
                    end
                    if (i_car2_lap_wrap) begin
                        lap2_q <= lap2_q + 1'b1;
                    end
                    if (win1 || win2) begin
                        state_q <= GAME_FINISHED;
                        if (win1 && win2) begin
                            result_q <= RESULT_TIE;
                        end else if (win1) begin
                            result_q <= RESULT_CAR1;
                        end else begin
                            result_q <= RESULT_CAR2;
                        end
                    end
                end
                GAME_FINISHED: begin
                    if (next_rise) begin
                        state_q  <= GAME_IDLE;
                        result_q <= RESULT_NONE;
                        lap1_q   <= '0;
                        lap2_q   <= '0;
                    end
                end
                default: state_q <= GAME_IDLE;
            endcase
        end
    end

    // the clear pulse lines up with the edge that moves the game back to idle.
    assign o_clear      = (state_q == GAME_FINISHED) && next_rise;
    assign o_racing     = (state_q == GAME_RACING);
    assign o_game_state = state_q;
    assign o_result     = result_q;
    assign o_car1_lap   = lap1_q;
    assign o_car2_lap   = lap2_q;

    // a lap pulse can only follow a tick taken while the race was running.
    a_wrap_only_racing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_car1_lap_wrap || i_car2_lap_wrap) |-> $past(o_racing));

endmodule

//--- rtl/car_physics.sv
`timescale 1ns/1ps

module car_physics #(
    parameter race_pkg::lane_t START_LANE = 4'd4
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_frame_tick,
    input  logic                 i_racing,
    input  logic                 i_clear,
    input  race_pkg::car_ctrl_t  i_ctrl,
    output race_pkg::car_state_t o_state,
    output logic                 o_lap_wrap,
    output logic                 o_vibrate
);

    import race_pkg::*;

    localparam car_state_t START_STATE = '{pos: 8'd0, lane: START_LANE, speed: 4'd0};

    car_state_t state_q;
    speed_t     speed_next;
    lane_t      lane_next;
    logic [4:0] speed_up;
    logic [2:0] speed_down;
    logic [8:0] pos_sum;
    logic       blocked;

    // codes 4..7 accelerate by code-4, codes 0..3 brake by 4-code.
    always_comb begin
        speed_up   = {1'b0, state_q.speed} + {3'b000, i_ctrl.acc[1:0]};
        speed_down = 3'd4 - i_ctrl.acc;
        if (i_ctrl.acc[2]) begin
            speed_next = (speed_up > {1'b0, MAX_SPEED}) ? MAX_SPEED : speed_up[3:0];
        end else if (state_q.speed < {1'b0, speed_down}) begin
            speed_next = '0;
        end else begin
            speed_next = state_q.speed - {1'b0, speed_down};
        end
    end

    // bit 8 is the carry past the end of the lap.
    assign pos_sum = {1'b0, state_q.pos} + {5'd0, speed_next};

    always_comb begin
        lane_next = state_q.lane;
        blocked   = 1'b0;
        case (i_ctrl.steer)
            STEER_LEFT: begin
                if (state_q.lane == '0) begin
                    blocked = 1'b1;
                end else begin
                    lane_next = state_q.lane - 4'd1;
                end
            end
            STEER_RIGHT: begin
                if (state_q.lane == LANE_MAX) begin
                    blocked = 1'b1;
                end else begin
                    lane_next = state_q.lane + 4'd1;
                end
            end
            default: lane_next = state_q.lane;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= START_STATE;
            o_lap_wrap <= 1'b0;
            o_vibrate  <= 1'b0;
        end else if (i_clear) begin
            state_q    <= START_STATE;
            o_lap_wrap <= 1'b0;
            o_vibrate  <= 1'b0;
        end else begin
            o_lap_wrap <= 1'b0;
            if (i_frame_tick) begin
                // vibration holds for the whole frame after a blocked move.
                o_vibrate <= i_racing && blocked;
                if (i_racing) begin
                    state_q.speed <= speed_next;
                    state_q.pos   <= pos_sum[7:0];
                    state_q.lane  <= lane_next;
                    o_lap_wrap    <= pos_sum[8];
                end
            end
        end
    end

    assign o_state = state_q;

    a_speed_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state_q.speed <= MAX_SPEED);

endmodule

//--- rtl/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 192,
    parameter int H_TOTAL  = 240,
    parameter int V_ACTIVE = 144,
    parameter int V_TOTAL  = 160,
    parameter int H_SYNC_W = 16,
    parameter int V_SYNC_W = 4
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    output logic [7:0] o_h,
    output logic [7:0] o_v,
    output logic       o_active,
    output logic       o_frame_tick,
    output logic       o_h_sync,
    output logic       o_v_sync
);

    localparam logic [7:0] H_LAST       = 8'(H_TOTAL - 1);
    localparam logic [7:0] V_LAST       = 8'(V_TOTAL - 1);
    localparam logic [8:0] H_SYNC_START = 9'(H_ACTIVE);
    localparam logic [8:0] H_SYNC_END   = 9'(H_ACTIVE + H_SYNC_W);
    localparam logic [8:0] V_SYNC_START = 9'(V_ACTIVE);
    localparam logic [8:0] V_SYNC_END   = 9'(V_ACTIVE + V_SYNC_W);

    logic [7:0] h_cnt;
    logic [7:0] v_cnt;
    logic       h_wrap;
    logic       v_wrap;
    logic       tick_q;

    assign h_wrap = (h_cnt == H_LAST);
    assign v_wrap = (v_cnt == V_LAST);

    // the tick is registered so it lands in the cycle where both counters read zero.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            tick_q <= 1'b0;
        end else begin
            tick_q <= h_wrap && v_wrap;
            if (h_wrap) begin
                h_cnt <= '0;
                if (v_wrap) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 8'd1;
                end
            end else begin
                h_cnt <= h_cnt + 8'd1;
            end
        end
    end

    assign o_h          = h_cnt;
    assign o_v          = v_cnt;
    assign o_frame_tick = tick_q;
    assign o_active     = ({1'b0, h_cnt} < H_SYNC_START) && ({1'b0, v_cnt} < V_SYNC_START);

    // sync pulses sit at the start of each blanking interval.
    assign o_h_sync = !(({1'b0, h_cnt} >= H_SYNC_START) && ({1'b0, h_cnt} < H_SYNC_END));
    assign o_v_sync = !(({1'b0, v_cnt} >= V_SYNC_START) && ({1'b0, v_cnt} < V_SYNC_END));

    a_tick_at_origin: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_frame_tick |-> (o_h == 8'd0 && o_v == 8'd0));

endmodule

//--- rtl/race_pkg.sv
package race_pkg;

    typedef logic [7:0]  pos_t;
    typedef logic [3:0]  lane_t;
    typedef logic [3:0]  speed_t;
    typedef logic [23:0] rgb_t;

    typedef struct packed {
        pos_t   pos;
        lane_t  lane;
        speed_t speed;
    } car_state_t;

    // hold is treated as no steering by the physics.
    typedef enum logic [1:0] {
        STEER_NONE  = 2'd0,
        STEER_LEFT  = 2'd1,
        STEER_RIGHT = 2'd2,
        STEER_HOLD  = 2'd3
    } steer_e;

    typedef struct packed {
        logic [2:0] acc;
        steer_e     steer;
    } car_ctrl_t;

    typedef enum logic [1:0] {
        GAME_IDLE     = 2'd0,
        GAME_RACING   = 2'd1,
        GAME_FINISHED = 2'd2
    } game_state_e;

    typedef enum logic [1:0] {
        RESULT_NONE = 2'd0,
        RESULT_CAR1 = 2'd1,
        RESULT_CAR2 = 2'd2,
        RESULT_TIE  = 2'd3
    } game_result_e;

    localparam rgb_t COLOR_CAR1    = 24'hff0000;
    localparam rgb_t COLOR_CAR2    = 24'h0000ff;
    localparam rgb_t COLOR_TRACK_A = 24'h505050;
    localparam rgb_t COLOR_TRACK_B = 24'h808080;
    localparam rgb_t COLOR_FINISH  = 24'hffffff;
    localparam rgb_t COLOR_BLANK   = 24'h000000;

    localparam speed_t MAX_SPEED = 4'd12;
    localparam lane_t  LANE_MAX  = 4'd15;
    localparam int     CAR_SIZE  = 4;
    localparam int     LAP_WIDTH = 3;

    // bit index is row * CAR_SIZE + column; the four corners are see-through.
    localparam logic [15:0] CAR_MASK = 16'b0110_1111_1111_0110;

endpackage
